/* logic/ahb_out_config.svh */
// Widths of the fixed four-port output stage; AHB_PORT_W must stay 2 for four ports
`ifndef AHB_OUT_CONFIG_SVH
`define AHB_OUT_CONFIG_SVH

// --------------------------------------------------------------------------
// Bus widths
// --------------------------------------------------------------------------
`define AHB_ADDR_W   32  // HADDR width
`define AHB_DATA_W   32  // HWDATA width
`define AHB_MASTER_W 4   // HMASTER width

// --------------------------------------------------------------------------
// Port count
// --------------------------------------------------------------------------
`define AHB_PORT_W   2   // Index of one of four ports

`endif

/* logic/ahb_out_pkg.sv */
// Shared types for the output stage; struct field order is the port packing order
`default_nettype none

`include "ahb_out_config.svh"

package ahb_out_pkg;

  // AHB HTRANS encoding
  typedef enum logic [1:0]
  {
    IDLE   = 2'b00,  // No transfer
    BUSY   = 2'b01,  // Burst pause
    NONSEQ = 2'b10,  // First beat
    SEQ    = 2'b11   // Burst continuation
  } htrans_t;

  // Input port index
  typedef logic [`AHB_PORT_W-1:0] port_idx_t;

  // Address phase fields of one port, MSB first
  typedef struct packed
  {
    logic                     sel;       // HSEL
    logic [`AHB_ADDR_W-1:0]   addr;      // HADDR
    htrans_t                  trans;     // HTRANS
    logic                     write;     // HWRITE
    logic [2:0]               size;      // HSIZE
    logic [2:0]               burst;     // HBURST
    logic [3:0]               prot;      // HPROT
    logic [`AHB_MASTER_W-1:0] master;    // HMASTER
    logic                     mastlock;  // HMASTLOCK
  } addr_ctrl_t;

endpackage

`default_nettype wire

/* logic/ahb_port_mux.sv */
// Four-way payload selector; output is all zeros while i_en is low
`timescale 1ns/1ps
`default_nettype none

module ahb_port_mux
  import ahb_out_pkg::*;
#(
  parameter type payload_t = logic  // Routed payload
)
(
  input  port_idx_t i_sel,  // Routed port
  input  logic      i_en,   // Route enable
  input  payload_t  i_in0,  // Port 0 payload
  input  payload_t  i_in1,  // Port 1 payload
  input  payload_t  i_in2,  // Port 2 payload
  input  payload_t  i_in3,  // Port 3 payload
  output payload_t  o_out   // Selected payload
);

  always_comb
  begin : p_mux
    o_out = '0;  // Idle bus value
    if (i_en)
    begin
      case (i_sel)
        2'd0: o_out = i_in0;
        2'd1: o_out = i_in1;
        2'd2: o_out = i_in2;
        2'd3: o_out = i_in3;
      endcase
    end
  end

endmodule

`default_nettype wire

/* logic/ahb_out_arb.sv */
// Round-robin burst arbiter; grant only moves on a ready edge, port 0 first after reset
`timescale 1ns/1ps
`default_nettype none

module ahb_out_arb
  import ahb_out_pkg::*;
(
  input  logic       HCLK,            // AHB clock
  input  logic       HRESETn,         // Sync reset, active low
  input  logic [3:0] i_req,           // Held transfer and select per port
  input  logic       i_ready,         // HREADYMUXM
  input  logic       i_hselm,         // Routed slave select
  input  htrans_t    i_htransm,       // Routed transfer type
  input  logic       i_hlock_arb,     // Lock level seen by arbitration
  output port_idx_t  o_addr_in_port,  // Address phase port
  output logic       o_no_port        // No port granted
);

  port_idx_t addr_in_port;  // Granted port, also last granted
  logic      no_port;       // Nothing granted
  port_idx_t next_port;     // Round-robin winner
  logic      next_no_port;  // No request pending
  logic      grant_hold;    // Keep current grant

  // --------------------------------------------------------------------------
  // Hold conditions
  // --------------------------------------------------------------------------
  // Rest of a burst stays with the current port, as does a locked sequence
  assign grant_hold = i_hlock_arb |
                      (i_hselm & ((i_htransm == BUSY) | (i_htransm == SEQ)));

  // --------------------------------------------------------------------------
  // Round-robin search
  // --------------------------------------------------------------------------
  // Walks offsets 4 down to 1 so the nearest port after the grant wins
  always_comb
  begin : p_next_grant
    port_idx_t cand;
    cand         = addr_in_port;
    next_port    = addr_in_port;  // Index kept with no requests
    next_no_port = 1'b1;
    for (int k = 4; k >= 1; k--)
    begin
      cand = addr_in_port + port_idx_t'(k);  // Offset 4 wraps to current port
      if (i_req[cand])
      begin
        next_port    = cand;
        next_no_port = 1'b0;
      end
    end
  end

  // --------------------------------------------------------------------------
  // Grant register
  // --------------------------------------------------------------------------
  always_ff @(posedge HCLK)
  begin : p_grant_reg
    if (!HRESETn)
    begin
      addr_in_port <= '1;    // Port 3 as last grant, port 0 goes first
      no_port      <= 1'b1;
    end
    else if (i_ready && !grant_hold)
    begin
      addr_in_port <= next_port;
      no_port      <= next_no_port;
    end
  end

  assign o_addr_in_port = addr_in_port;
  assign o_no_port      = no_port;

endmodule

`default_nettype wire

/* logic/ahb_addr_stage.sv */
// Address phase routing; lock tracking assumes HMASTLOCK stays high across a deselect
`timescale 1ns/1ps
`default_nettype none

module ahb_addr_stage
  import ahb_out_pkg::*;
(
  input  logic       HCLK,            // AHB clock
  input  logic       HRESETn,         // Sync reset, active low
  input  port_idx_t  i_addr_in_port,  // Granted port
  input  logic       i_no_port,       // No port granted
  input  logic       i_ready,         // HREADYMUXM
  input  addr_ctrl_t i_port0,         // Port 0 address/control
  input  addr_ctrl_t i_port1,         // Port 1 address/control
  input  addr_ctrl_t i_port2,         // Port 2 address/control
  input  addr_ctrl_t i_port3,         // Port 3 address/control
  output addr_ctrl_t o_ctrl,          // Routed to slave
  output logic [3:0] o_active,        // One-hot active flags
  output logic       o_hlock_arb      // Lock level for arbiter
);

  addr_ctrl_t ctrl;       // Routed fields
  logic       hsel_lock;  // Locked sequence already started

  // Zero fields, so HSELM and HTRANSM idle, when nothing is granted
  ahb_port_mux #(
    .payload_t (addr_ctrl_t)
  ) u_addr_mux (
    .i_sel (i_addr_in_port),
    .i_en  (~i_no_port),
    .i_in0 (i_port0),
    .i_in1 (i_port1),
    .i_in2 (i_port2),
    .i_in3 (i_port3),
    .o_out (ctrl)
  );

  always_comb
  begin : p_active
    o_active = '0;
    if (!i_no_port)
      o_active[i_addr_in_port] = 1'b1;  // Flag the granted port
  end

  // --------------------------------------------------------------------------
  // Locked sequence tracking
  // --------------------------------------------------------------------------
  // Master may address another slave mid-lock with HSEL low; without this
  // register the arbiter would drop the lock and let another port in
  always_ff @(posedge HCLK)
  begin : p_hsel_lock
    if (!HRESETn)
      hsel_lock <= 1'b0;
    else if (i_ready)
    begin
      if (ctrl.sel && ctrl.trans[1] && ctrl.mastlock)
        hsel_lock <= 1'b1;  // Locked NONSEQ/SEQ seen
      else if (!ctrl.mastlock)
        hsel_lock <= 1'b0;  // Lock released
    end
  end

  // Mastlock masked by select unless the lock already began here
  assign o_hlock_arb = ctrl.mastlock & (hsel_lock | ctrl.sel);
  assign o_ctrl      = ctrl;

endmodule

`default_nettype wire

/* logic/ahb_data_stage.sv */
// Data phase of the shared slave; HWDATAM is zero outside a selected data phase
`timescale 1ns/1ps
`default_nettype none

`include "ahb_out_config.svh"

module ahb_data_stage
  import ahb_out_pkg::*;
(
  input  logic                   HCLK,            // AHB clock
  input  logic                   HRESETn,         // Sync reset, active low
  input  port_idx_t              i_addr_in_port,  // Address phase port
  input  logic                   i_hselm,         // Routed slave select
  input  logic [`AHB_DATA_W-1:0] i_wdata0,        // Port 0 write data
  input  logic [`AHB_DATA_W-1:0] i_wdata1,        // Port 1 write data
  input  logic [`AHB_DATA_W-1:0] i_wdata2,        // Port 2 write data
  input  logic [`AHB_DATA_W-1:0] i_wdata3,        // Port 3 write data
  input  logic                   i_hreadyoutm,    // Slave HREADYOUT
  output logic [`AHB_DATA_W-1:0] o_hwdatam,       // Write data to slave
  output logic                   o_ready          // HREADYMUXM
);

  port_idx_t data_in_port;  // Port owning the data phase
  logic      slave_sel;     // Slave selected in data phase

  // Address phase moves into data phase on each completed beat
  always_ff @(posedge HCLK)
  begin : p_data_phase
    if (!HRESETn)
    begin
      data_in_port <= '0;
      slave_sel    <= 1'b0;
    end
    else if (o_ready)
    begin
      data_in_port <= i_addr_in_port;
      slave_sel    <= i_hselm;
    end
  end

  ahb_port_mux #(
    .payload_t (logic [`AHB_DATA_W-1:0])
  ) u_wdata_mux (
    .i_sel (data_in_port),
    .i_en  (slave_sel),
    .i_in0 (i_wdata0),
    .i_in1 (i_wdata1),
    .i_in2 (i_wdata2),
    .i_in3 (i_wdata3),
    .o_out (o_hwdatam)
  );

  // Slave stalls only its own data phase
  assign o_ready = slave_sel ? i_hreadyoutm : 1'b1;

endmodule

`default_nettype wire

/* logic/ahb_out_stage.sv */
// AHB matrix output stage, four ports fixed; inputs must hold until the port is active
`timescale 1ns/1ps
`default_nettype none

`include "ahb_out_config.svh"

module ahb_out_stage
  import ahb_out_pkg::*;
(
  input  logic                     HCLK,            // AHB clock
  input  logic                     HRESETn,         // Sync reset, active low
  // Port 0
  input  logic                     i_sel_op0,       // HSEL
  input  logic [`AHB_ADDR_W-1:0]   i_addr_op0,      // HADDR
  input  logic [1:0]               i_trans_op0,     // HTRANS
  input  logic                     i_write_op0,     // HWRITE
  input  logic [2:0]               i_size_op0,      // HSIZE
  input  logic [2:0]               i_burst_op0,     // HBURST
  input  logic [3:0]               i_prot_op0,      // HPROT
  input  logic [`AHB_MASTER_W-1:0] i_master_op0,    // HMASTER
  input  logic                     i_mastlock_op0,  // HMASTLOCK
  input  logic [`AHB_DATA_W-1:0]   i_wdata_op0,     // HWDATA
  input  logic                     i_held_tran_op0, // Held transfer
  // Port 1
  input  logic                     i_sel_op1,
  input  logic [`AHB_ADDR_W-1:0]   i_addr_op1,
  input  logic [1:0]               i_trans_op1,
  input  logic                     i_write_op1,
  input  logic [2:0]               i_size_op1,
  input  logic [2:0]               i_burst_op1,
  input  logic [3:0]               i_prot_op1,
  input  logic [`AHB_MASTER_W-1:0] i_master_op1,
  input  logic                     i_mastlock_op1,
  input  logic [`AHB_DATA_W-1:0]   i_wdata_op1,
  input  logic                     i_held_tran_op1,
  // Port 2
  input  logic                     i_sel_op2,
  input  logic [`AHB_ADDR_W-1:0]   i_addr_op2,
  input  logic [1:0]               i_trans_op2,
  input  logic                     i_write_op2,
  input  logic [2:0]               i_size_op2,
  input  logic [2:0]               i_burst_op2,
  input  logic [3:0]               i_prot_op2,
  input  logic [`AHB_MASTER_W-1:0] i_master_op2,
  input  logic                     i_mastlock_op2,
  input  logic [`AHB_DATA_W-1:0]   i_wdata_op2,
  input  logic                     i_held_tran_op2,
  // Port 3
  input  logic                     i_sel_op3,
  input  logic [`AHB_ADDR_W-1:0]   i_addr_op3,
  input  logic [1:0]               i_trans_op3,
  input  logic                     i_write_op3,
  input  logic [2:0]               i_size_op3,
  input  logic [2:0]               i_burst_op3,
  input  logic [3:0]               i_prot_op3,
  input  logic [`AHB_MASTER_W-1:0] i_master_op3,
  input  logic                     i_mastlock_op3,
  input  logic [`AHB_DATA_W-1:0]   i_wdata_op3,
  input  logic                     i_held_tran_op3,
  // Shared slave
  input  logic                     i_hreadyoutm,    // Slave HREADYOUT
  output logic                     o_active_op0,    // Port 0 owns address phase
  output logic                     o_active_op1,    // Port 1 owns address phase
  output logic                     o_active_op2,    // Port 2 owns address phase
  output logic                     o_active_op3,    // Port 3 owns address phase
  output logic                     o_hselm,         // HSEL
  output logic [`AHB_ADDR_W-1:0]   o_haddrm,        // HADDR
  output logic [1:0]               o_htransm,       // HTRANS
  output logic                     o_hwritem,       // HWRITE
  output logic [2:0]               o_hsizem,        // HSIZE
  output logic [2:0]               o_hburstm,       // HBURST
  output logic [3:0]               o_hprotm,        // HPROT
  output logic [`AHB_MASTER_W-1:0] o_hmasterm,      // HMASTER
  output logic                     o_hmastlockm,    // HMASTLOCK
  output logic [`AHB_DATA_W-1:0]   o_hwdatam,       // HWDATA
  output logic                     o_hreadymuxm     // Transfer done
);

  addr_ctrl_t port_ctrl [4];  // Packed per-port fields
  addr_ctrl_t ctrl;           // Routed fields
  logic [3:0] req;            // Arbitration requests
  logic [3:0] active;         // One-hot active flags
  port_idx_t  addr_in_port;   // Granted port
  logic       no_port;        // Nothing granted
  logic       hlock_arb;      // Lock level for arbiter
  logic       ready;          // HREADYMUXM

  // --------------------------------------------------------------------------
  // Port packing, field order as addr_ctrl_t
  // --------------------------------------------------------------------------
  assign port_ctrl[0] = {i_sel_op0, i_addr_op0, i_trans_op0, i_write_op0, i_size_op0,
                         i_burst_op0, i_prot_op0, i_master_op0, i_mastlock_op0};
  assign port_ctrl[1] = {i_sel_op1, i_addr_op1, i_trans_op1, i_write_op1, i_size_op1,
                         i_burst_op1, i_prot_op1, i_master_op1, i_mastlock_op1};
  assign port_ctrl[2] = {i_sel_op2, i_addr_op2, i_trans_op2, i_write_op2, i_size_op2,
                         i_burst_op2, i_prot_op2, i_master_op2, i_mastlock_op2};
  assign port_ctrl[3] = {i_sel_op3, i_addr_op3, i_trans_op3, i_write_op3, i_size_op3,
                         i_burst_op3, i_prot_op3, i_master_op3, i_mastlock_op3};

  // Only a held transfer addressed to this slave competes
  assign req = {i_held_tran_op3 & i_sel_op3, i_held_tran_op2 & i_sel_op2,
                i_held_tran_op1 & i_sel_op1, i_held_tran_op0 & i_sel_op0};

  ahb_out_arb u_arb (
    .HCLK           (HCLK),
    .HRESETn        (HRESETn),
    .i_req          (req),
    .i_ready        (ready),
    .i_hselm        (ctrl.sel),
    .i_htransm      (ctrl.trans),
    .i_hlock_arb    (hlock_arb),
    .o_addr_in_port (addr_in_port),
    .o_no_port      (no_port)
  );

  ahb_addr_stage u_addr (
    .HCLK           (HCLK),
    .HRESETn        (HRESETn),
    .i_addr_in_port (addr_in_port),
    .i_no_port      (no_port),
    .i_ready        (ready),
    .i_port0        (port_ctrl[0]),
    .i_port1        (port_ctrl[1]),
    .i_port2        (port_ctrl[2]),
    .i_port3        (port_ctrl[3]),
    .o_ctrl         (ctrl),
    .o_active       (active),
    .o_hlock_arb    (hlock_arb)
  );

  ahb_data_stage u_data (
    .HCLK           (HCLK),
    .HRESETn        (HRESETn),
    .i_addr_in_port (addr_in_port),
    .i_hselm        (ctrl.sel),
    .i_wdata0       (i_wdata_op0),
    .i_wdata1       (i_wdata_op1),
    .i_wdata2       (i_wdata_op2),
    .i_wdata3       (i_wdata_op3),
    .i_hreadyoutm   (i_hreadyoutm),
    .o_hwdatam      (o_hwdatam),
    .o_ready        (ready)
  );

  // --------------------------------------------------------------------------
  // Slave outputs
  // --------------------------------------------------------------------------
  assign {o_active_op3, o_active_op2, o_active_op1, o_active_op0} = active;

  assign o_hselm      = ctrl.sel;
  assign o_haddrm     = ctrl.addr;
  assign o_htransm    = ctrl.trans;
  assign o_hwritem    = ctrl.write;
  assign o_hsizem     = ctrl.size;
  assign o_hburstm    = ctrl.burst;
  assign o_hprotm     = ctrl.prot;
  assign o_hmasterm   = ctrl.master;
  assign o_hmastlockm = ctrl.mastlock;
  assign o_hreadymuxm = ready;

endmodule

`default_nettype wire

/* sim/ahb_out_props.sv */
// Checks on the active flags; bound to the top level, needs the internal active vector
`timescale 1ns/1ps
`default_nettype none

module ahb_out_props
(
  input wire       HCLK,            // AHB clock
  input wire       HRESETn,         // Sync reset, active low
  input wire [3:0] i_active,        // One-hot active flags
  input wire       i_hselm,         // Routed slave select
  input wire       i_hreadymuxm     // Transfer done
);

  // At most one port owns the address phase
  a_onehot0 : assert property (@(posedge HCLK) disable iff (!HRESETn)
    $onehot0(i_active))
    else $error("active flags not zero-or-one-hot");

  // A selected slave always has an owner
  a_sel_owner : assert property (@(posedge HCLK) disable iff (!HRESETn)
    i_hselm |-> $onehot(i_active))
    else $error("slave selected without a single active port");

  // Wait state freezes the grant
  a_stall_hold : assert property (@(posedge HCLK) disable iff (!HRESETn)
    !i_hreadymuxm |=> $stable(i_active))
    else $error("active flags changed during a wait state");

endmodule

bind ahb_out_stage ahb_out_props u_props (
  .HCLK         (HCLK),
  .HRESETn      (HRESETn),
  .i_active     (active),
  .i_hselm      (o_hselm),
  .i_hreadymuxm (o_hreadymuxm)
);

`default_nettype wire

/* sim/ahb_out_stage_tb.sv */
// Testbench for the output stage; write/size/burst/prot/master are taken from address bits
`timescale 1ns/1ps
`default_nettype none

`include "ahb_out_config.svh"

module ahb_out_stage_tb
  import ahb_out_pkg::*;
;

  logic                   HCLK;
  logic                   HRESETn;
  logic                   hreadyout;                // Slave HREADYOUT
  logic                   sel [4];                  // Per-port select
  logic [`AHB_ADDR_W-1:0] addr [4];                 // Per-port address
  logic [1:0]             trans [4];                // Per-port HTRANS
  logic                   mlock [4];                // Per-port HMASTLOCK
  logic [`AHB_DATA_W-1:0] wdata [4];                // Per-port write data
  logic                   held [4];                 // Held transfer flags
  wire  [3:0]             act;                      // Active flags
  wire                    hselm, hwritem, hmastlockm, hreadymuxm;
  wire  [`AHB_ADDR_W-1:0] haddrm;
  wire  [1:0]             htransm;
  wire  [2:0]             hsizem, hburstm;
  wire  [3:0]             hprotm;
  wire  [`AHB_MASTER_W-1:0] hmasterm;
  wire  [`AHB_DATA_W-1:0] hwdatam;
  integer                 seed = 20;                // Random seed
  int                     errors = 0;
  int                     tests_run = 0;
  int                     tests_bad = 0;
  logic [1:0]             m_g = 2'd3;               // Model grant
  logic                   m_no = 1'b1;              // Model no-port
  logic                   m_hlock = 1'b0;           // Model held lock
  logic                   m_dsel = 1'b0;            // Model data-phase select
  logic [1:0]             m_dport = 2'd0;           // Model data-phase port

  ahb_out_stage uut (
    .HCLK (HCLK), .HRESETn (HRESETn),
    .i_sel_op0 (sel[0]), .i_addr_op0 (addr[0]), .i_trans_op0 (trans[0]),
    .i_write_op0 (addr[0][4]), .i_size_op0 (addr[0][7:5]), .i_burst_op0 (addr[0][10:8]),
    .i_prot_op0 (addr[0][14:11]), .i_master_op0 (addr[0][18:15]),
    .i_mastlock_op0 (mlock[0]), .i_wdata_op0 (wdata[0]), .i_held_tran_op0 (held[0]),
    .i_sel_op1 (sel[1]), .i_addr_op1 (addr[1]), .i_trans_op1 (trans[1]),
    .i_write_op1 (addr[1][4]), .i_size_op1 (addr[1][7:5]), .i_burst_op1 (addr[1][10:8]),
    .i_prot_op1 (addr[1][14:11]), .i_master_op1 (addr[1][18:15]),
    .i_mastlock_op1 (mlock[1]), .i_wdata_op1 (wdata[1]), .i_held_tran_op1 (held[1]),
    .i_sel_op2 (sel[2]), .i_addr_op2 (addr[2]), .i_trans_op2 (trans[2]),
    .i_write_op2 (addr[2][4]), .i_size_op2 (addr[2][7:5]), .i_burst_op2 (addr[2][10:8]),
    .i_prot_op2 (addr[2][14:11]), .i_master_op2 (addr[2][18:15]),
    .i_mastlock_op2 (mlock[2]), .i_wdata_op2 (wdata[2]), .i_held_tran_op2 (held[2]),
    .i_sel_op3 (sel[3]), .i_addr_op3 (addr[3]), .i_trans_op3 (trans[3]),
    .i_write_op3 (addr[3][4]), .i_size_op3 (addr[3][7:5]), .i_burst_op3 (addr[3][10:8]),
    .i_prot_op3 (addr[3][14:11]), .i_master_op3 (addr[3][18:15]),
    .i_mastlock_op3 (mlock[3]), .i_wdata_op3 (wdata[3]), .i_held_tran_op3 (held[3]),
    .i_hreadyoutm (hreadyout),
    .o_active_op0 (act[0]), .o_active_op1 (act[1]),
    .o_active_op2 (act[2]), .o_active_op3 (act[3]),
    .o_hselm (hselm), .o_haddrm (haddrm), .o_htransm (htransm), .o_hwritem (hwritem),
    .o_hsizem (hsizem), .o_hburstm (hburstm), .o_hprotm (hprotm), .o_hmasterm (hmasterm),
    .o_hmastlockm (hmastlockm), .o_hwdatam (hwdatam), .o_hreadymuxm (hreadymuxm)
  );

  initial
  begin : p_clk
    HCLK = 1'b0;
    forever #2 HCLK = ~HCLK;  // 4 ns period
  end

  // Round-robin pick after last grant; MSB set when nothing requests
  function automatic logic [2:0] next_grant(input logic [1:0] last, input logic [3:0] req);
    logic [1:0] c;
    logic [2:0] pick;
    pick = {1'b1, last};
    for (int k = 1; k <= 4; k++)
    begin
      c = last + 2'(k);  // Offset 4 wraps to last
      if (req[c] && pick[2])
        pick = {1'b0, c};
    end
    return pick;
  endfunction

  // --------------------------------------------------------------------------
  // Reference model and per-edge compare
  // --------------------------------------------------------------------------
  always @(posedge HCLK)
  begin : p_check
    logic [3:0] req, e_act;
    logic       e_sel, e_ml, e_ready, hold;
    logic [1:0] e_tr;
    logic [2:0] ng;
    logic [`AHB_ADDR_W-1:0] e_addr;
    logic [`AHB_DATA_W-1:0] e_wd;
    if (!HRESETn)
    begin
      m_g     = 2'd3;
      m_no    = 1'b1;
      m_hlock = 1'b0;
      m_dsel  = 1'b0;
      m_dport = 2'd0;
    end
    else
    begin
      e_sel   = m_no ? 1'b0 : sel[m_g];
      e_tr    = m_no ? 2'b00 : trans[m_g];
      e_ml    = m_no ? 1'b0 : mlock[m_g];
      e_addr  = m_no ? '0 : addr[m_g];
      e_act   = m_no ? 4'b0 : (4'b1 << m_g);
      e_ready = m_dsel ? hreadyout : 1'b1;
      e_wd    = m_dsel ? wdata[m_dport] : '0;
      assert (act == e_act && hselm == e_sel && htransm == e_tr && haddrm == e_addr &&
              hmastlockm == e_ml && hwritem == e_addr[4] && hsizem == e_addr[7:5] &&
              hburstm == e_addr[10:8] && hprotm == e_addr[14:11] &&
              hmasterm == e_addr[18:15])
      else
      begin
        $display("error %0t: address phase act=%b exp %b haddr=%h exp %h", $time,
                 act, e_act, haddrm, e_addr);
        errors++;
      end
      assert (hreadymuxm == e_ready && hwdatam == e_wd)
      else
      begin
        $display("error %0t: data phase ready=%b exp %b hwdata=%h exp %h", $time,
                 hreadymuxm, e_ready, hwdatam, e_wd);
        errors++;
      end
      if (e_ready)
      begin
        hold = (e_ml & (m_hlock | e_sel)) | (e_sel & (e_tr == 2'b01 || e_tr == 2'b11));
        if (e_sel && e_tr[1] && e_ml)
          m_hlock = 1'b1;
        else if (!e_ml)
          m_hlock = 1'b0;
        m_dsel  = e_sel;
        m_dport = m_g;  // Old grant enters data phase
        if (!hold)
        begin
          for (int i = 0; i < 4; i++)
            req[i] = held[i] & sel[i];
          ng   = next_grant(m_g, req);
          m_g  = ng[1:0];
          m_no = ng[2];
        end
      end
    end
  end

  // --------------------------------------------------------------------------
  // Helpers
  // --------------------------------------------------------------------------
  task automatic stop_on_timeout(input string what);
    $display("timeout while waiting for %s", what);
    $display("Simulation FAILED");
    $finish;
  endtask

  task automatic wait_active(input int p, input int limit);
    int n;
    n = 0;
    @(negedge HCLK);
    while (!act[p] && n < limit)
    begin
      n++;
      @(negedge HCLK);
    end
    if (!act[p])
      stop_on_timeout($sformatf("port %0d to become active", p));
  endtask

  task automatic set_port(input int p, input logic s, input logic [1:0] t, input logic ml);
    sel[p]   = s;
    held[p]  = s;
    trans[p] = t;
    mlock[p] = ml;
    addr[p]  = $random(seed);
    wdata[p] = $random(seed);
  endtask

  task automatic clear_ports();
    for (int i = 0; i < 4; i++)
      set_port(i, 1'b0, 2'b00, 1'b0);
    hreadyout = 1'b1;
  endtask

  task automatic apply_reset();
    HRESETn = 1'b0;
    repeat (2) @(posedge HCLK);
    @(negedge HCLK);
    HRESETn = 1'b1;
  endtask

  task automatic check_act(input logic [3:0] exp, input string what);
    assert (act == exp)
    else
    begin
      $display("error %0t: %s act=%b exp %b", $time, what, act, exp);
      errors++;
    end
  endtask

  task automatic end_test(input string name, input int base);
    tests_run++;
    if (errors != base)
      tests_bad++;
    $display("test %s: %s", name, (errors == base) ? "ok" : "errors found");
  endtask

  // --------------------------------------------------------------------------
  // Tests
  // --------------------------------------------------------------------------
  initial
  begin : p_main
    int base, p;
    logic [2:0] ng;
    logic [`AHB_DATA_W-1:0] wd;
    HRESETn = 1'b0;
    clear_ports();
    apply_reset();

    base = errors;  // Reset state
    check_act(4'b0, "reset");
    assert (!hselm && htransm == IDLE && hreadymuxm)
    else
    begin
      $display("error %0t: reset outputs wrong", $time);
      errors++;
    end
    end_test("reset_state", base);

    base = errors;  // Single port
    p = $random(seed) & 3;
    set_port(p, 1'b1, NONSEQ, 1'b0);
    wait_active(p, 10);
    assert (haddrm == addr[p] && hselm)
    else
    begin
      $display("error %0t: haddr=%h exp %h", $time, haddrm, addr[p]);
      errors++;
    end
    @(negedge HCLK);
    assert (hwdatam == wdata[p])
    else
    begin
      $display("error %0t: hwdata=%h exp %h", $time, hwdatam, wdata[p]);
      errors++;
    end
    clear_ports();
    end_test("single_port", base);

    base = errors;  // Round robin from reset
    apply_reset();
    for (int i = 0; i < 4; i++)
      set_port(i, 1'b1, NONSEQ, 1'b0);
    ng = 3'd3;
    for (int i = 0; i < 8; i++)
    begin
      ng = next_grant(ng[1:0], 4'hf);
      @(negedge HCLK);
      check_act(4'b1 << ng[1:0], "round robin");
    end
    end_test("round_robin", base);

    base = errors;  // Burst hold on port 1
    set_port(1, 1'b1, SEQ, 1'b0);
    wait_active(1, 10);
    repeat (5)
    begin
      @(negedge HCLK);
      check_act(4'b0010, "burst hold");
    end
    trans[1] = NONSEQ;
    @(negedge HCLK);
    check_act(4'b0100, "burst end");
    clear_ports();
    end_test("burst_hold", base);

    base = errors;  // Wait states
    set_port(0, 1'b1, NONSEQ, 1'b0);
    wait_active(0, 10);
    set_port(3, 1'b1, NONSEQ, 1'b0);
    hreadyout = 1'b0;
    @(negedge HCLK);
    wd = hwdatam;  // Port 0 in data phase, port 3 owns address phase
    repeat (3)
    begin
      assert (!hreadymuxm && hwdatam == wd)
      else
      begin
        $display("error %0t: stall ready=%b hwdata=%h exp %h", $time, hreadymuxm,
                 hwdatam, wd);
        errors++;
      end
      check_act(4'b1000, "wait state");
      @(negedge HCLK);
    end
    hreadyout = 1'b1;
    @(negedge HCLK);
    check_act(4'b0001, "after wait");
    clear_ports();
    end_test("wait_states", base);

    base = errors;  // Lock across deselect on port 2
    set_port(2, 1'b1, NONSEQ, 1'b1);
    wait_active(2, 10);
    set_port(0, 1'b1, NONSEQ, 1'b0);
    set_port(3, 1'b1, NONSEQ, 1'b0);
    @(negedge HCLK);
    sel[2] = 1'b0;  // Deselect, lock kept
    repeat (4)
    begin
      @(negedge HCLK);
      check_act(4'b0100, "lock hold");
    end
    mlock[2] = 1'b0;
    @(negedge HCLK);
    check_act(4'b1000, "lock release");
    clear_ports();
    end_test("lock_deselect", base);

    @(negedge HCLK);
    $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_bad, errors);
    if (errors == 0)
      $display("Simulation PASSED");
    else
      $display("Simulation FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* sim.f */
+incdir+logic
logic/ahb_out_pkg.sv
logic/ahb_port_mux.sv
logic/ahb_out_arb.sv
logic/ahb_addr_stage.sv
logic/ahb_data_stage.sv
logic/ahb_out_stage.sv
sim/ahb_out_props.sv
sim/ahb_out_stage_tb.sv

/* Makefile */
VERILATOR  ?= verilator
FLAGS      ?= --timing --assert
TOP        ?= ahb_out_stage_tb
FILELIST   ?= sim.f
LOG        ?= sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
